// File: Makefile
TOP = demosaicTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o $(TOP)

# The log decides the result
run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: demosaicGeomPkg.sv
package demosaicGeomPkg;

	// Frame size
	localparam int FrameWidth = 16;
	localparam int FrameHeight = 8;

	// Beats from window centre to the emitting beat
	localparam int InterpStages = 3;
	// Beats needed to push the last pixel of a frame out of the pipeline
	localparam int FlushBeats = FrameWidth + 1 + InterpStages;
	localparam int CreditDepth = 4;

	// Register counts along the pipeline
	localparam int WindowDepth = FrameWidth + 2;
	localparam int InterpRegs = InterpStages - 1;
	localparam int PipeDepth = WindowDepth + InterpRegs;

	localparam int CoordWidth = 5;
	localparam int LineAddrWidth = $clog2(FrameWidth);
	localparam int CreditWidth = $clog2(CreditDepth + 1);
	localparam int FlushWidth = $clog2(FlushBeats + 1);

	typedef logic [CoordWidth-1:0] coord_t;
	typedef logic [LineAddrWidth-1:0] lineAddr_t;
	typedef logic [CreditWidth-1:0] credit_t;
	typedef logic [FlushWidth-1:0] flushCount_t;

	localparam coord_t LastX = coord_t'(FrameWidth - 1);
	localparam coord_t LastY = coord_t'(FrameHeight - 1);
	localparam lineAddr_t LastAddr = lineAddr_t'(FrameWidth - 1);

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic lastPixel;
	} pixelPos_t;

	typedef enum logic [1:0] {
		green,
		blueSite,
		redSite
	} bayerSite_t;

	// Colour filter under a position, from row and column parity
	function automatic bayerSite_t siteOf(pixelPos_t pos);
		if (pos.x[0] == pos.y[0])
			return green;
		else if (!pos.y[0])
			return blueSite;
		return redSite;
	endfunction

endpackage

// File: demosaicPixelPkg.sv
package demosaicPixelPkg;

	typedef logic [7:0] pixel_t;

	// Cross-shaped neighbourhood around the pixel being interpolated
	typedef struct packed {
		pixel_t centre;
		pixel_t up;
		pixel_t down;
		pixel_t left;
		pixel_t right;
	} window_t;

	// Set where the neighbour lies inside the frame
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
	} nbrPresent_t;

	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	typedef logic [31:0] accum_t;
	typedef logic [7:0] threshold_t;

	// Frame gradient sum boundaries
	localparam accum_t FLevel0 = 1000;
	localparam accum_t FLevel1 = 2000;
	localparam accum_t FLevel2 = 4000;
	localparam accum_t FLevel3 = 8000;

	// Smoother frames get a higher edge threshold
	localparam threshold_t TLevel0 = 50;
	localparam threshold_t TLevel1 = 40;
	localparam threshold_t TLevel2 = 20;
	localparam threshold_t TLevel3 = 15;
	localparam threshold_t TLevel4 = 8;

	localparam threshold_t ThresholdReset = 8;

endpackage

// File: demosaicModel.svh
`ifndef demosaicModelSvh
`define demosaicModelSvh

// Every frame as it was sent, indexed [frame][row][column]
pixel_t framePixels [NumFrames][FrameHeight][FrameWidth];

// Sample at a position, zero anywhere outside the frame
function automatic int sampleAt(int frame, int x, int y);
	if (x < 0 || x >= FrameWidth || y < 0 || y >= FrameHeight)
		return 0;
	return int'(framePixels[frame][y][x]);
endfunction

function automatic int absDelta(int a, int b);
	if (a >= b)
		return a - b;
	return b - a;
endfunction

// Estimate along one axis from whichever neighbours exist
function automatic int axisEstimate(int a, int b, bit hasA, bit hasB);
	if (hasA && hasB)
		return (a + b) / 2;
	if (hasA)
		return a;
	return b;
endfunction

function automatic bit isGreenSite(int x, int y);
	return (x % 2) == (y % 2);
endfunction

function automatic rgb_t expectedRgb(int frame, int x, int y);
	int centre;
	int up;
	int down;
	int left;
	int right;
	int hGrad;
	int vGrad;
	int vEst;
	int hEst;
	int est;
	rgb_t res;
	centre = sampleAt(frame, x, y);
	up = sampleAt(frame, x, y - 1);
	down = sampleAt(frame, x, y + 1);
	left = sampleAt(frame, x - 1, y);
	right = sampleAt(frame, x + 1, y);
	vEst = axisEstimate(up, down, y > 0, y < FrameHeight - 1);
	hEst = axisEstimate(left, right, x > 0, x < FrameWidth - 1);
	hGrad = absDelta(left, right);
	vGrad = absDelta(up, down);
	if (hGrad > vGrad)
		est = vEst;
	else if (hGrad < vGrad)
		est = hEst;
	else
		est = (hEst + vEst) / 2;
	res = '0;
	if (isGreenSite(x, y)) begin
		res.g = pixel_t'(centre);
	end else if ((y % 2) == 0) begin
		// Blue sits on even rows
		res.b = pixel_t'(centre);
		res.g = pixel_t'(est);
	end else begin
		res.r = pixel_t'(centre);
		res.g = pixel_t'(est);
	end
	return res;
endfunction

// Table lookup on the frame's summed gradients at red and blue sites
function automatic threshold_t expectedThreshold(int frame);
	accum_t total;
	total = '0;
	for (int y = 0; y < FrameHeight; y++) begin
		for (int x = 0; x < FrameWidth; x++) begin
			if (!isGreenSite(x, y)) begin
				total += accum_t'(absDelta(sampleAt(frame, x - 1, y), sampleAt(frame, x + 1, y)));
				total += accum_t'(absDelta(sampleAt(frame, x, y - 1), sampleAt(frame, x, y + 1)));
			end
		end
	end
	if (total < FLevel0)
		return TLevel0;
	if (total < FLevel1)
		return TLevel1;
	if (total < FLevel2)
		return TLevel2;
	if (total < FLevel3)
		return TLevel3;
	return TLevel4;
endfunction

`endif

// File: demosaicTb.sv
`timescale 1ns/100ps

module demosaicTb;
	import demosaicGeomPkg::*;
	import demosaicPixelPkg::*;

	localparam int NumFrames = 3;
	localparam int FramePixels = FrameWidth * FrameHeight;
	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 8;
	// Three frames of pixels and flush beats at eight cycles per beat
	localparam int WatchdogNs = NumFrames * (FramePixels + FlushBeats) * 8 * ClockPeriod;

	typedef struct packed {
		logic [7:0] frame;
		pixelPos_t pos;
	} expectItem_t;

	logic clk;
	logic reset;
	pixel_t inPixel;
	logic inValid;
	logic inReady;
	logic outCredit;
	logic outValid;
	rgb_t outRgb;
	pixelPos_t outPos;
	threshold_t outThreshold;

	integer seed;
	int errors;
	int received;
	int frameOutputs;
	int emitted;
	int creditsReturned;
	int cycleCount;
	threshold_t expThreshold;
	expectItem_t expectQ [$];
	int creditDue [$];

	`include "demosaicModel.svh"

	demosaicTop dut (
		.clk(clk),
		.reset(reset),
		.inPixel(inPixel),
		.inValid(inValid),
		.inReady(inReady),
		.outCredit(outCredit),
		.outValid(outValid),
		.outRgb(outRgb),
		.outPos(outPos),
		.outThreshold(outThreshold)
	);

	always #(ClockPeriod / 2) clk = ~clk;

	task automatic checkValue(string what, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			errors++;
			$display("FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	// Hold the pixel until a cycle with inReady high has passed
	task automatic sendPixel(input pixel_t value);
		inPixel = value;
		inValid = 1'b1;
		do @(negedge clk); while (!inReady);
		@(posedge clk);
		#2;
		inValid = 1'b0;
	endtask

	// Narrow ranges give smooth frames and high thresholds
	function automatic pixel_t pixelMask(int frame);
		case (frame)
			0: return 8'h0f;
			1: return 8'hff;
			default: return 8'h3f;
		endcase
	endfunction

	initial begin
		expectItem_t item;
		pixel_t value;
		int gap;
		clk = 1'b0;
		reset = 1'b1;
		inPixel = '0;
		inValid = 1'b0;
		outCredit = 1'b0;
		seed = 32'h4fae0047;
		errors = 0;
		received = 0;
		frameOutputs = 0;
		emitted = 0;
		creditsReturned = 0;
		cycleCount = 0;
		expThreshold = ThresholdReset;
		repeat (ResetCycles) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int f = 0; f < NumFrames; f++) begin
			for (int y = 0; y < FrameHeight; y++) begin
				for (int x = 0; x < FrameWidth; x++) begin
					value = pixel_t'($random(seed)) & pixelMask(f);
					framePixels[f][y][x] = value;
					item.frame = 8'(f);
					item.pos.x = coord_t'(x);
					item.pos.y = coord_t'(y);
					item.pos.lastPixel = (x == FrameWidth - 1) && (y == FrameHeight - 1);
					expectQ.push_back(item);
					sendPixel(value);
					// Occasional idle cycles on the input
					gap = ((($random(seed) & 32'h3) == 0) ? 1 + ($random(seed) & 32'h1) : 0);
					repeat (gap) begin
						@(posedge clk);
						#2;
					end
				end
			end
		end
		wait (received == NumFrames * FramePixels);
		// Any extra output would show up here
		repeat (2 * FlushBeats) @(posedge clk);
		checkValue("total outputs", emitted, NumFrames * FramePixels);
		$display("Run complete: %0d outputs checked, %0d errors", received, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Consumer returns at most one credit pulse per cycle once due
	always @(posedge clk) begin
		cycleCount++;
		#2;
		if (creditDue.size() != 0 && creditDue[0] <= cycleCount) begin
			outCredit = 1'b1;
			void'(creditDue.pop_front());
		end else begin
			outCredit = 1'b0;
		end
	end

	// Outputs are stable mid-cycle and emission happens at the next edge
	always @(negedge clk) begin
		expectItem_t item;
		int delay;
		if (!reset) begin
			checkValue("outThreshold", outThreshold, expThreshold);
			if (outValid) begin
				emitted++;
				checkValue("emitted within credits", emitted <= CreditDepth + creditsReturned, 1);
				if (expectQ.size() == 0) begin
					errors++;
					$display("Output at %0d ns has no input pixel left to match it", $time);
				end else begin
					item = expectQ.pop_front();
					checkValue("outPos", outPos, item.pos);
					checkValue("outRgb", outRgb,
						expectedRgb(int'(item.frame), int'(item.pos.x), int'(item.pos.y)));
					received++;
					frameOutputs++;
					if (outPos.lastPixel) begin
						checkValue("outputs in frame", frameOutputs, FramePixels);
						frameOutputs = 0;
					end
					// Threshold loads at the coming edge
					if (item.pos.lastPixel)
						expThreshold = expectedThreshold(int'(item.frame));
				end
				delay = {$random(seed)} % 6;
				creditDue.push_back(cycleCount + 1 + delay);
			end
			if (outCredit)
				creditsReturned++;
		end
	end

	initial begin
		#(WatchdogNs);
		$display("Timeout: the run did not finish within %0d ns and was stopped", WatchdogNs);
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: demosaicTop.sv
`timescale 1ns/100ps

module demosaicTop (
	input logic clk,
	input logic reset,
	input demosaicPixelPkg::pixel_t inPixel,
	input logic inValid,
	output logic inReady,
	input logic outCredit,
	output logic outValid,
	output demosaicPixelPkg::rgb_t outRgb,
	output demosaicGeomPkg::pixelPos_t outPos,
	output demosaicPixelPkg::threshold_t outThreshold
);
	import demosaicGeomPkg::*;
	import demosaicPixelPkg::*;

	logic advance;
	logic headValid;
	logic tailValid;
	pixelPos_t headPos;
	pixelPos_t centrePos;
	window_t window;
	nbrPresent_t present;
	logic [8:0] gradSum;
	bayerSite_t site;

	rasterSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.outCredit(outCredit),
		.tailValid(tailValid),
		.inReady(inReady),
		.advance(advance),
		.headPos(headPos),
		.headValid(headValid),
		.flushing()
	);

	// Valid bit runs alongside the whole datapath
	stageDelay #(.payload_t(logic), .Depth(PipeDepth)) validDelay (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.din(headValid),
		.dout(tailValid)
	);

	lineWindow window3x3 (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.inPixel(inPixel),
		.headPos(headPos),
		.window(window),
		.present(present),
		.centrePos(centrePos)
	);

	greenInterp interp (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.window(window),
		.present(present),
		.centrePos(centrePos),
		.rgb(outRgb),
		.gradSum(gradSum),
		.site(site),
		.rgbPos(outPos)
	);

	edgeThreshold threshold (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.gradSum(gradSum),
		.site(site),
		.pixelValid(tailValid),
		.lastPixel(outPos.lastPixel),
		.threshold(outThreshold)
	);

	// Tail item is emitted on the beat it leaves
	assign outValid = tailValid && advance;

endmodule

// File: edgeThreshold.sv
`timescale 1ns/100ps

module edgeThreshold (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic [8:0] gradSum,
	input demosaicGeomPkg::bayerSite_t site,
	input logic pixelValid,
	input logic lastPixel,
	output demosaicPixelPkg::threshold_t threshold
);
	import demosaicGeomPkg::*;
	import demosaicPixelPkg::*;

	accum_t frameSum;
	accum_t nextSum;
	logic emitting;

	// Busier frames map to lower thresholds
	function automatic threshold_t pickThreshold(accum_t total);
		if (total < FLevel0)
			return TLevel0;
		else if (total < FLevel1)
			return TLevel1;
		else if (total < FLevel2)
			return TLevel2;
		else if (total < FLevel3)
			return TLevel3;
		return TLevel4;
	endfunction

	assign emitting = advance && pixelValid;

	// Only red and blue sites carry gradients
	assign nextSum = (site == green) ? frameSum : frameSum + accum_t'(gradSum);

	always_ff @(posedge clk) begin
		if (reset) begin
			frameSum <= '0;
			threshold <= ThresholdReset;
		end else if (emitting) begin
			if (lastPixel) begin
				threshold <= pickThreshold(nextSum);
				frameSum <= '0;
			end else begin
				frameSum <= nextSum;
			end
		end
	end

endmodule

// File: greenInterp.sv
`timescale 1ns/100ps

module greenInterp (
	input logic clk,
	input logic reset,
	input logic advance,
	input demosaicPixelPkg::window_t window,
	input demosaicPixelPkg::nbrPresent_t present,
	input demosaicGeomPkg::pixelPos_t centrePos,
	output demosaicPixelPkg::rgb_t rgb,
	output logic [8:0] gradSum,
	output demosaicGeomPkg::bayerSite_t site,
	output demosaicGeomPkg::pixelPos_t rgbPos
);
	import demosaicGeomPkg::*;
	import demosaicPixelPkg::*;

	pixel_t vEst;
	pixel_t hEst;
	pixel_t hGrad;
	pixel_t vGrad;
	pixel_t greenEst;
	pixel_t centreDly;

	// Mean of a pair, falling back to whichever one is present
	function automatic pixel_t pairMean(pixel_t a, pixel_t b, logic aOk, logic bOk);
		logic [8:0] total;
		total = {1'b0, a} + {1'b0, b};
		if (aOk && bOk)
			return total[8:1];
		else if (aOk)
			return a;
		return b;
	endfunction

	function automatic pixel_t absDiff(pixel_t a, pixel_t b);
		return (a > b) ? a - b : b - a;
	endfunction

	// Stage 1: directional estimates and gradients
	always_ff @(posedge clk) begin
		if (advance) begin
			vEst <= pairMean(window.up, window.down, present.up, present.down);
			hEst <= pairMean(window.left, window.right, present.left, present.right);
			hGrad <= absDiff(window.left, window.right);
			vGrad <= absDiff(window.up, window.down);
		end
	end

	// Stage 2: interpolate along the flatter direction
	always_ff @(posedge clk) begin
		if (advance) begin
			if (hGrad > vGrad)
				greenEst <= vEst;
			else if (hGrad < vGrad)
				greenEst <= hEst;
			else
				greenEst <= pairMean(hEst, vEst, 1'b1, 1'b1);
			gradSum <= {1'b0, hGrad} + {1'b0, vGrad};
		end
	end

	stageDelay #(.payload_t(pixel_t), .Depth(InterpRegs)) centreDelay (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.din(window.centre),
		.dout(centreDly)
	);

	stageDelay #(.payload_t(pixelPos_t), .Depth(InterpRegs)) posDelay (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.din(centrePos),
		.dout(rgbPos)
	);

	// Stage 3: place the sample and the estimate by filter colour
	assign site = siteOf(rgbPos);

	always_comb begin
		rgb = '0;
		case (site)
			blueSite: begin
				rgb.g = greenEst;
				rgb.b = centreDly;
			end
			redSite: begin
				rgb.r = centreDly;
				rgb.g = greenEst;
			end
			default: begin
				rgb.g = centreDly;
			end
		endcase
	end

endmodule

// File: lineWindow.sv
`timescale 1ns/100ps

module lineWindow (
	input logic clk,
	input logic reset,
	input logic advance,
	input demosaicPixelPkg::pixel_t inPixel,
	input demosaicGeomPkg::pixelPos_t headPos,
	output demosaicPixelPkg::window_t window,
	output demosaicPixelPkg::nbrPresent_t present,
	output demosaicGeomPkg::pixelPos_t centrePos
);
	import demosaicGeomPkg::*;
	import demosaicPixelPkg::*;

	// Line A holds the previous row, line B the one before it
	pixel_t lineA [FrameWidth];
	pixel_t lineB [FrameWidth];
	lineAddr_t linePtr;
	pixel_t tapA;
	pixel_t tapB;

	// Index 0 is the newest pixel in each row
	pixel_t bottomRow [2];
	pixel_t middleRow [3];
	pixel_t topRow [2];

	assign tapA = lineA[linePtr];
	assign tapB = lineB[linePtr];

	always_ff @(posedge clk) begin
		if (reset) begin
			linePtr <= '0;
		end else if (advance) begin
			linePtr <= (linePtr == LastAddr) ? '0 : linePtr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			lineA[linePtr] <= inPixel;
			lineB[linePtr] <= tapA;
			bottomRow[0] <= inPixel;
			bottomRow[1] <= bottomRow[0];
			middleRow[0] <= tapA;
			middleRow[1] <= middleRow[0];
			middleRow[2] <= middleRow[1];
			topRow[0] <= tapB;
			topRow[1] <= topRow[0];
		end
	end

	// Position of the pixel now sitting in middleRow[1]
	stageDelay #(.payload_t(pixelPos_t), .Depth(WindowDepth)) posDelay (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.din(headPos),
		.dout(centrePos)
	);

	assign present.up = (centrePos.y != '0);
	assign present.down = (centrePos.y != LastY);
	assign present.left = (centrePos.x != '0);
	assign present.right = (centrePos.x != LastX);

	// Neighbours outside the frame read as zero
	assign window.centre = middleRow[1];
	assign window.up = present.up ? topRow[1] : '0;
	assign window.down = present.down ? bottomRow[1] : '0;
	assign window.left = present.left ? middleRow[2] : '0;
	assign window.right = present.right ? middleRow[0] : '0;

endmodule

// File: rasterSequencer.sv
`timescale 1ns/100ps

module rasterSequencer (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outCredit,
	input logic tailValid,
	output logic inReady,
	output logic advance,
	output demosaicGeomPkg::pixelPos_t headPos,
	output logic headValid,
	output logic flushing
);
	import demosaicGeomPkg::*;

	coord_t xCount;
	coord_t yCount;
	flushCount_t flushLeft;
	credit_t credits;
	logic slotFree;
	logic transfer;
	logic spend;
	logic frameEnd;

	// Tail can move if it is empty or a credit covers its item
	assign slotFree = !tailValid || (credits != '0);
	assign flushing = (flushLeft != '0);
	assign inReady = slotFree && !flushing;
	assign transfer = inValid && inReady;
	assign advance = transfer || (flushing && slotFree);

	// A valid tail item leaves on every advance
	assign spend = advance && tailValid;

	assign frameEnd = (xCount == LastX) && (yCount == LastY);
	assign headPos = '{x: xCount, y: yCount, lastPixel: frameEnd};
	assign headValid = transfer;

	// Raster position of the next accepted pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			xCount <= '0;
			yCount <= '0;
		end else if (transfer) begin
			if (xCount == LastX) begin
				xCount <= '0;
				yCount <= (yCount == LastY) ? '0 : yCount + 1'b1;
			end else begin
				xCount <= xCount + 1'b1;
			end
		end
	end

	// Empty beats after the frame's last pixel drain the pipeline
	always_ff @(posedge clk) begin
		if (reset) begin
			flushLeft <= '0;
		end else if (transfer && frameEnd) begin
			flushLeft <= flushCount_t'(FlushBeats);
		end else if (advance && flushing) begin
			flushLeft <= flushLeft - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= credit_t'(CreditDepth);
		end else begin
			credits <= credits + credit_t'(outCredit) - credit_t'(spend);
		end
	end

	// Consumer never returns more credits than it was given
	creditBound: assert property (
		@(posedge clk) disable iff (reset) credits <= credit_t'(CreditDepth)
	);

endmodule

// File: sources.f
+incdir+.
demosaicGeomPkg.sv
demosaicPixelPkg.sv
stageDelay.sv
lineWindow.sv
rasterSequencer.sv
greenInterp.sv
edgeThreshold.sv
demosaicTop.sv
demosaicTb.sv

// File: stageDelay.sv
`timescale 1ns/100ps

module stageDelay #(
	parameter type payload_t = logic,
	parameter int Depth = 1
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input payload_t din,
	output payload_t dout
);

	payload_t stages [Depth];

	// Moves one register per beat, holds otherwise
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < Depth; i++) begin
				stages[i] <= '0;
			end
		end else if (advance) begin
			stages[0] <= din;
			for (int i = 1; i < Depth; i++) begin
				stages[i] <= stages[i - 1];
			end
		end
	end

	assign dout = stages[Depth - 1];

endmodule
